// ==== Bender.yml ====
package:
  name: cnn_layer_engine

sources:
  - design/cnn_pkg.sv
  - design/layer_ctrl.sv
  - design/mem_unit.sv
  - design/layer_alu.sv
  - design/conv_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/tb_checker.sv
      - verification/conv_assert.sv
      - verification/tb_top.sv

// ==== design/cnn_pkg.sv ====
package cnn_pkg;

    //==========================================================================
    // Widths and image geometry
    //==========================================================================
    // Pixels are signed Q4.16
    localparam int data_w = 20;
    localparam int frac_w = 16;
    localparam int acc_w  = 44;
    localparam int addr_w = 12;

    localparam int img_w  = 64;
    localparam int pool_w = img_w / 2;
    localparam int taps   = 9;

    // Cycles per output pixel
    localparam int conv_steps = taps + 5;
    localparam int pool_taps  = 4;
    localparam int pool_steps = pool_taps + 2;

    //==========================================================================
    // Coefficients
    //==========================================================================
    // Row-major from the top-left tap
    localparam logic signed [data_w-1:0] kernel [taps] = '{
        20'h0A89E,
        20'h092D5,
        20'h06D43,
        20'h01004,
        20'hF8F71,
        20'hF6E54,
        20'hFA6D7,
        20'hFC834,
        20'hFAC19
    };

    localparam logic signed [data_w-1:0] conv_bias = 20'h01310;

    //==========================================================================
    // Types
    //==========================================================================
    typedef enum logic [1:0] {
        lay_idle,
        lay_conv,
        lay_pool
    } layer_e;

    typedef enum logic [2:0] {
        op_clear,
        op_mac,
        op_bias,
        op_round,
        op_relu,
        op_max,
        op_hold
    } alu_op_e;

    typedef enum logic [1:0] {
        sel_none,
        sel_l0,
        sel_l1
    } mem_sel_e;

    // Read for tap t travels with the operation for tap t-1
    typedef struct packed {
        layer_e             layer;
        logic               rd_en;
        logic signed [7:0]  rd_row;
        logic signed [7:0]  rd_col;
        alu_op_e            op;
        logic [3:0]         op_tap;
        logic               wr_en;
        logic [6:0]         wr_row;
        logic [6:0]         wr_col;
    } step_t;

endpackage

// ==== design/conv_top.sv ====
`timescale 1ns/1ps

module conv_top import cnn_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ready,
    output logic              busy,
    output logic [addr_w-1:0] iaddr,
    input  logic [data_w-1:0] idata,
    output logic              crd,
    output logic [addr_w-1:0] caddr_rd,
    input  logic [data_w-1:0] cdata_rd,
    output logic              cwr,
    output logic [addr_w-1:0] caddr_wr,
    output logic [data_w-1:0] cdata_wr,
    output mem_sel_e          csel
);

    step_t                    step;
    logic signed [data_w-1:0] operand;
    logic        [data_w-1:0] result;

    // Sequencing of reads, ALU operations and writes
    layer_ctrl u_ctrl (
        .clk   (clk),
        .reset (reset),
        .ready (ready),
        .busy  (busy),
        .step  (step)
    );

    mem_unit u_mem (
        .clk      (clk),
        .reset    (reset),
        .step     (step),
        .idata    (idata),
        .cdata_rd (cdata_rd),
        .result   (result),
        .iaddr    (iaddr),
        .crd      (crd),
        .caddr_rd (caddr_rd),
        .cwr      (cwr),
        .caddr_wr (caddr_wr),
        .cdata_wr (cdata_wr),
        .csel     (csel),
        .operand  (operand)
    );

    layer_alu u_alu (
        .clk     (clk),
        .reset   (reset),
        .step    (step),
        .operand (operand),
        .result  (result)
    );

endmodule

// ==== design/layer_alu.sv ====
`timescale 1ns/1ps

module layer_alu import cnn_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  step_t                    step,
    input  logic signed [data_w-1:0] operand,
    output logic        [data_w-1:0] result
);

    logic signed [acc_w-1:0]    acc;
    logic signed [acc_w-1:0]    acc_next;
    logic signed [acc_w-1:0]    opnd_ext;
    logic signed [2*data_w-1:0] product;
    logic        [data_w-1:0]   rounded;

    assign product  = operand * kernel[step.op_tap];
    assign opnd_ext = acc_w'(operand);

    // Q.32 product sum back to Q4.16, half rounds up
    assign rounded = acc[frac_w+data_w-1:frac_w] + data_w'(acc[frac_w-1]);

    //==========================================================================
    // Next accumulator value
    //==========================================================================
    always_comb
    begin
        case (step.op)
            op_clear:
            begin
                acc_next = '0;
            end
            op_mac:
            begin
                acc_next = acc + acc_w'(product);
            end
            op_bias:
            begin
                // Bias aligned to the product's fraction bits
                acc_next = acc + (acc_w'(conv_bias) <<< frac_w);
            end
            op_round:
            begin
                acc_next = acc_w'($signed(rounded));
            end
            op_relu:
            begin
                acc_next = (acc < 0) ? '0 : acc;
            end
            op_max:
            begin
                // First window value loads unconditionally
                if ((step.op_tap == 4'd0) || (opnd_ext > acc))
                    acc_next = opnd_ext;
                else
                    acc_next = acc;
            end
            default:
            begin
                acc_next = acc;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            acc <= '0;
        else
            acc <= acc_next;
    end

    assign result = acc[data_w-1:0];

endmodule

// ==== design/layer_ctrl.sv ====
`timescale 1ns/1ps

module layer_ctrl import cnn_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  ready,
    output logic  busy,
    output step_t step
);

    layer_e            layer_q;
    logic [3:0]        step_cnt;
    logic [3:0]        tap_cnt;
    logic [5:0]        row_cnt;
    logic [5:0]        col_cnt;
    logic              start;
    logic              rd_en;
    logic              last_step;
    logic              last_col;
    logic              last_row;
    logic              pix_end;
    logic signed [7:0] row_off;
    logic signed [7:0] col_off;

    assign start = (layer_q == lay_idle) && ready;

    assign last_step = (layer_q == lay_conv) ? (step_cnt == conv_steps - 1)
                                             : (step_cnt == pool_steps - 1);
    assign last_col  = (layer_q == lay_conv) ? (col_cnt == img_w - 1) : (col_cnt == pool_w - 1);
    assign last_row  = (layer_q == lay_conv) ? (row_cnt == img_w - 1) : (row_cnt == pool_w - 1);
    assign pix_end   = (layer_q != lay_idle) && last_step;

    assign rd_en = ((layer_q == lay_conv) && (step_cnt < taps)) ||
                   ((layer_q == lay_pool) && (step_cnt < pool_taps));

    //==========================================================================
    // Layer FSM and busy
    //==========================================================================
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            layer_q <= lay_idle;
            busy    <= 1'b0;
        end
        else
        begin
            // Stays high one cycle past the last pool write
            busy <= start || (layer_q != lay_idle);
            case (layer_q)
                lay_idle:
                begin
                    if (ready)
                        layer_q <= lay_conv;
                end
                lay_conv:
                begin
                    if (pix_end && last_col && last_row)
                        layer_q <= lay_pool;
                end
                lay_pool:
                begin
                    if (pix_end && last_col && last_row)
                        layer_q <= lay_idle;
                end
                default:
                begin
                    layer_q <= lay_idle;
                end
            endcase
        end
    end

    //==========================================================================
    // Step, tap and position counters
    //==========================================================================
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            step_cnt <= '0;
            tap_cnt  <= '0;
            row_cnt  <= '0;
            col_cnt  <= '0;
        end
        else
        begin
            // Tap read this cycle is the tap operated on next cycle
            if (rd_en)
                tap_cnt <= step_cnt;
            if (layer_q == lay_idle)
            begin
                step_cnt <= '0;
                row_cnt  <= '0;
                col_cnt  <= '0;
            end
            else
            begin
                step_cnt <= last_step ? 4'd0 : step_cnt + 4'd1;
                if (last_step)
                begin
                    if (last_col)
                    begin
                        col_cnt <= '0;
                        row_cnt <= last_row ? 6'd0 : row_cnt + 6'd1;
                    end
                    else
                    begin
                        col_cnt <= col_cnt + 6'd1;
                    end
                end
            end
        end
    end

    // Conv window offsets, row-major around the centre
    always_comb
    begin
        if (step_cnt < 3)
            row_off = -8'sd1;
        else if (step_cnt < 6)
            row_off = 8'sd0;
        else
            row_off = 8'sd1;
        case (step_cnt)
            4'd0, 4'd3, 4'd6: col_off = -8'sd1;
            4'd1, 4'd4, 4'd7: col_off = 8'sd0;
            default:          col_off = 8'sd1;
        endcase
    end

    //==========================================================================
    // Step word
    //==========================================================================
    always_comb
    begin
        step        = '0;
        step.layer  = layer_q;
        step.rd_en  = rd_en;
        step.op     = op_hold;
        step.op_tap = tap_cnt;
        step.wr_en  = pix_end;
        step.wr_row = {1'b0, row_cnt};
        step.wr_col = {1'b0, col_cnt};
        if (layer_q == lay_conv)
        begin
            step.rd_row = $signed({2'b00, row_cnt}) + row_off;
            step.rd_col = $signed({2'b00, col_cnt}) + col_off;
            if (step_cnt == 0)
                step.op = op_clear;
            else if (step_cnt <= taps)
                step.op = op_mac;
            else if (step_cnt == taps + 1)
                step.op = op_bias;
            else if (step_cnt == taps + 2)
                step.op = op_round;
            else if (step_cnt == taps + 3)
                step.op = op_relu;
        end
        else if (layer_q == lay_pool)
        begin
            // 2x2 window anchored at twice the output position
            step.rd_row = {2'b00, row_cnt[4:0], step_cnt[1]};
            step.rd_col = {2'b00, col_cnt[4:0], step_cnt[0]};
            if ((step_cnt >= 1) && (step_cnt <= pool_taps))
                step.op = op_max;
        end
    end

endmodule

// ==== design/mem_unit.sv ====
`timescale 1ns/1ps

module mem_unit import cnn_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  step_t                    step,
    input  logic        [data_w-1:0] idata,
    input  logic        [data_w-1:0] cdata_rd,
    input  logic        [data_w-1:0] result,
    output logic        [addr_w-1:0] iaddr,
    output logic                     crd,
    output logic        [addr_w-1:0] caddr_rd,
    output logic                     cwr,
    output logic        [addr_w-1:0] caddr_wr,
    output logic        [data_w-1:0] cdata_wr,
    output mem_sel_e                 csel,
    output logic signed [data_w-1:0] operand
);

    logic conv_rd;
    logic pool_rd;
    logic out_of_img;
    logic pad_q;
    logic pool_q;

    assign conv_rd = step.rd_en && (step.layer == lay_conv);
    assign pool_rd = step.rd_en && (step.layer == lay_pool);

    // Border taps of the conv window fall outside the image
    assign out_of_img = ($signed(step.rd_row) < 0) || ($signed(step.rd_row) >= img_w) ||
                        ($signed(step.rd_col) < 0) || ($signed(step.rd_col) >= img_w);

    //==========================================================================
    // Addresses and strobes
    //==========================================================================
    assign iaddr = (conv_rd && !out_of_img) ? addr_w'(step.rd_row * img_w + step.rd_col)
                                            : '0;

    // Pool reads come from the 64-wide layer-0 result
    assign crd      = pool_rd;
    assign caddr_rd = pool_rd ? addr_w'(step.rd_row * img_w + step.rd_col) : '0;

    assign cwr      = step.wr_en;
    assign cdata_wr = result;

    always_comb
    begin
        if (!step.wr_en)
            caddr_wr = '0;
        else if (step.layer == lay_pool)
            caddr_wr = addr_w'(step.wr_row * pool_w + step.wr_col);
        else
            caddr_wr = addr_w'(step.wr_row * img_w + step.wr_col);
    end

    always_comb
    begin
        if (pool_rd)
            csel = sel_l0;
        else if (step.wr_en)
            csel = (step.layer == lay_pool) ? sel_l1 : sel_l0;
        else
            csel = sel_none;
    end

    //==========================================================================
    // Operand source, one cycle behind the read
    //==========================================================================
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pad_q  <= 1'b0;
            pool_q <= 1'b0;
        end
        else
        begin
            pad_q  <= conv_rd && out_of_img;
            pool_q <= pool_rd;
        end
    end

    assign operand = pad_q ? '0 : (pool_q ? cdata_rd : idata);

endmodule

// ==== src.f ====
design/cnn_pkg.sv
design/layer_ctrl.sv
design/mem_unit.sv
design/layer_alu.sv
design/conv_top.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/conv_assert.sv
verification/tb_top.sv

// ==== verification/conv_assert.sv ====
`timescale 1ns/1ps

module conv_assert import cnn_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     busy,
    input logic     crd,
    input logic     cwr,
    input mem_sel_e csel
);

    // Number of failed assertions
    int fail_count = 0;

    // One result memory access per cycle
    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset) !(cwr && crd))
        else
        begin
            fail_count++;
            $error("cwr and crd high in the same cycle");
        end

    a_idle_select: assert property (@(posedge clk) disable iff (reset)
                                    (!cwr && !crd) |-> (csel == sel_none))
        else
        begin
            fail_count++;
            $error("csel not sel_none while no access is made");
        end

    a_write_in_run: assert property (@(posedge clk) disable iff (reset) cwr |-> busy)
        else
        begin
            fail_count++;
            $error("Result write while busy is low");
        end

endmodule

bind conv_top conv_assert u_assert (
    .clk   (clk),
    .reset (reset),
    .busy  (busy),
    .crd   (crd),
    .cwr   (cwr),
    .csel  (csel)
);

// ==== verification/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import cnn_pkg::*;
(
    input logic              clk,
    input logic              reset,
    input logic              busy,
    input logic              crd,
    input logic              cwr,
    input mem_sel_e          csel,
    input logic [addr_w-1:0] caddr_wr,
    input logic [data_w-1:0] cdata_wr
);

    logic signed [data_w-1:0] image      [img_w*img_w];
    logic signed [data_w-1:0] conv_model [img_w*img_w];
    logic signed [data_w-1:0] pool_model [pool_w*pool_w];
    bit                       l0_seen    [img_w*img_w];
    bit                       l1_seen    [pool_w*pool_w];
    int                       run_idx;
    int                       l0_count;
    int                       l1_count;
    int                       l0_errors;
    int                       l1_errors;
    int                       tests_run;
    int                       tests_failed;
    int                       total_errors;

    //==========================================================================
    // Reference model
    //==========================================================================
    function automatic logic signed [data_w-1:0] conv_pixel(input int row, input int col);
        longint            acc;
        int                r;
        int                c;
        logic [data_w-1:0] rounded;
        acc = longint'(conv_bias) <<< frac_w;
        for (int t = 0; t < taps; t++)
        begin
            r = row + t / 3 - 1;
            c = col + t % 3 - 1;
            // Pixels beyond the border count as zero
            if ((r >= 0) && (r < img_w) && (c >= 0) && (c < img_w))
                acc += longint'(image[r * img_w + c]) * longint'(kernel[t]);
        end
        // Half up, then back to Q4.16
        rounded = data_w'((acc + (longint'(1) <<< (frac_w - 1))) >>> frac_w);
        return rounded[data_w-1] ? '0 : rounded;
    endfunction

    function automatic logic signed [data_w-1:0] pool_pixel(input int row, input int col);
        logic signed [data_w-1:0] best;
        logic signed [data_w-1:0] v;
        best = conv_model[2 * row * img_w + 2 * col];
        for (int k = 1; k < 4; k++)
        begin
            v = conv_model[(2 * row + k / 2) * img_w + 2 * col + k % 2];
            if (v > best)
                best = v;
        end
        return best;
    endfunction

    function automatic void set_pixel(input int addr, input logic [data_w-1:0] value);
        image[addr] = value;
    endfunction

    task automatic start_run(input int idx);
        run_idx   = idx;
        l0_count  = 0;
        l1_count  = 0;
        l0_errors = 0;
        l1_errors = 0;
        for (int a = 0; a < img_w * img_w; a++)
            l0_seen[a] = 1'b0;
        for (int a = 0; a < pool_w * pool_w; a++)
            l1_seen[a] = 1'b0;
        for (int r = 0; r < img_w; r++)
            for (int c = 0; c < img_w; c++)
                conv_model[r * img_w + c] = conv_pixel(r, c);
        for (int r = 0; r < pool_w; r++)
            for (int c = 0; c < pool_w; c++)
                pool_model[r * pool_w + c] = pool_pixel(r, c);
    endtask

    //==========================================================================
    // Write port monitor
    //==========================================================================
    task automatic check_l0_write(input int addr, input logic [data_w-1:0] data);
        if (l1_count != 0)
        begin
            $display("Layer-0 write to %03h after pooling had started", addr);
            l0_errors++;
        end
        if (l0_seen[addr])
        begin
            $display("Layer-0 address %03h written more than once", addr);
            l0_errors++;
        end
        if (data !== conv_model[addr])
        begin
            $display("Mismatch cdata_wr l0[%03h]: expected %05h, got %05h",
                     addr, conv_model[addr], data);
            l0_errors++;
        end
        l0_seen[addr] = 1'b1;
        l0_count++;
    endtask

    task automatic check_l1_write(input int addr, input logic [data_w-1:0] data);
        if (addr >= pool_w * pool_w)
        begin
            $display("Layer-1 write address %03h is outside the pooled image", addr);
            l1_errors++;
        end
        else
        begin
            if (l1_seen[addr])
            begin
                $display("Layer-1 address %03h written more than once", addr);
                l1_errors++;
            end
            if (data !== pool_model[addr])
            begin
                $display("Mismatch cdata_wr l1[%03h]: expected %05h, got %05h",
                         addr, pool_model[addr], data);
                l1_errors++;
            end
            l1_seen[addr] = 1'b1;
        end
        l1_count++;
    endtask

    // Mid-cycle, where the DUT outputs have settled
    always @(negedge clk)
    begin
        if (!reset && cwr)
        begin
            if (csel == sel_l0)
                check_l0_write(int'(caddr_wr), cdata_wr);
            else if (csel == sel_l1)
                check_l1_write(int'(caddr_wr), cdata_wr);
            else
            begin
                $display("Write strobe raised with no result memory selected");
                l0_errors++;
            end
        end
    end

    //==========================================================================
    // Reporting
    //==========================================================================
    task automatic report_test(input string name, input int errs);
        tests_run++;
        total_errors += errs;
        if (errs == 0)
            $display("PASS  %s", name);
        else
        begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, errs);
        end
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] want, inout int errs);
        if (got !== want)
        begin
            $display("Mismatch %s: expected %0h, got %0h", name, want, got);
            errs++;
        end
    endtask

    task automatic check_idle_outputs();
        int errs;
        errs = 0;
        @(negedge clk);
        expect_value("busy", busy, 0, errs);
        expect_value("cwr", cwr, 0, errs);
        expect_value("crd", crd, 0, errs);
        expect_value("csel", csel, sel_none, errs);
        report_test("outputs idle after reset", errs);
    endtask

    task automatic finish_run();
        if (l0_count != img_w * img_w)
        begin
            $display("Run %0d produced %0d layer-0 writes instead of %0d",
                     run_idx, l0_count, img_w * img_w);
            l0_errors++;
        end
        if (l1_count != pool_w * pool_w)
        begin
            $display("Run %0d produced %0d layer-1 writes instead of %0d",
                     run_idx, l1_count, pool_w * pool_w);
            l1_errors++;
        end
        report_test($sformatf("run %0d convolution layer", run_idx), l0_errors);
        report_test($sformatf("run %0d pooling layer", run_idx), l1_errors);
    endtask

    task automatic print_totals();
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
    endtask

    function automatic bit all_passed();
        return (tests_failed == 0) && (total_errors == 0);
    endfunction

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
(
    output logic clk
);

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

endmodule

// ==== verification/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import cnn_pkg::*;
();

    logic              clk;
    logic              reset;
    logic              ready;
    logic              busy;
    logic [addr_w-1:0] iaddr;
    logic [data_w-1:0] idata = '0;
    logic              crd;
    logic [addr_w-1:0] caddr_rd;
    logic [data_w-1:0] cdata_rd = '0;
    logic              cwr;
    logic [addr_w-1:0] caddr_wr;
    logic [data_w-1:0] cdata_wr;
    mem_sel_e          csel;

    logic [data_w-1:0] image_mem [2**addr_w];
    logic [data_w-1:0] l0_mem    [2**addr_w];
    logic [data_w-1:0] l1_mem    [2**addr_w];
    logic [31:0]       lcg_state;

    tb_clock clk_gen (.clk(clk));

    conv_top uut (
        .clk      (clk),
        .reset    (reset),
        .ready    (ready),
        .busy     (busy),
        .iaddr    (iaddr),
        .idata    (idata),
        .crd      (crd),
        .caddr_rd (caddr_rd),
        .cdata_rd (cdata_rd),
        .cwr      (cwr),
        .caddr_wr (caddr_wr),
        .cdata_wr (cdata_wr),
        .csel     (csel)
    );

    tb_checker chk (
        .clk      (clk),
        .reset    (reset),
        .busy     (busy),
        .crd      (crd),
        .cwr      (cwr),
        .csel     (csel),
        .caddr_wr (caddr_wr),
        .cdata_wr (cdata_wr)
    );

    //==========================================================================
    // Memory models with one-cycle read latency
    //==========================================================================
    always @(posedge clk)
    begin
        idata <= image_mem[iaddr];
        if (crd)
            cdata_rd <= (csel == sel_l1) ? l1_mem[caddr_rd] : l0_mem[caddr_rd];
        if (cwr && (csel == sel_l0))
            l0_mem[caddr_wr] <= cdata_wr;
        else if (cwr && (csel == sel_l1))
            l1_mem[caddr_wr] <= cdata_wr;
    end

    //==========================================================================
    // Stimulus
    //==========================================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Pixels within [-2.0, 2.0) in Q4.16
    task automatic fill_image();
        logic signed [frac_w+1:0] raw;
        for (int a = 0; a < img_w * img_w; a++)
        begin
            lcg_state    = lcg_next(lcg_state);
            raw          = lcg_state[29:12];
            image_mem[a] = data_w'(raw);
            chk.set_pixel(a, data_w'(raw));
        end
    endtask

    task automatic run_engine(input int run_idx);
        fill_image();
        chk.start_run(run_idx);
        @(posedge clk);
        ready <= 1'b1;
        @(posedge clk);
        ready <= 1'b0;
        while (!busy)
            @(posedge clk);
        while (busy)
            @(posedge clk);
        chk.finish_run();
    endtask

    initial
    begin
        reset     = 1'b1;
        ready     = 1'b0;
        lcg_state = 32'ha4b5;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        chk.check_idle_outputs();
        for (int r = 0; r < 2; r++)
            run_engine(r);
        chk.report_test("result port assertions", uut.u_assert.fail_count);
        chk.print_totals();
        if (chk.all_passed())
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Two full runs of conv and pool steps and a 20 percent margin
    initial
    begin : watchdog
        int limit;
        limit = 2 * (img_w * img_w * conv_steps + pool_w * pool_w * pool_steps + 1) * 12 / 10;
        repeat (limit) @(posedge clk);
        $display("Timeout: the engine did not finish within %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule
